// ==== bench/tb_tl_fifo_mem.sv ====
`default_nettype none

`include "tl_defines.svh"

module tb_tl_fifo_mem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Period     = 40;
  localparam int unsigned NumReq     = 16;
  localparam int unsigned LimitCycle = NumReq * 4 * 40;

  typedef struct packed {
    tl_pkg::a_op_e                 op;
    logic [`TL_SIZE_WIDTH-1:0]     size;
    logic [`TL_ADDR_WIDTH-1:0]     addr;
    logic [`TL_HOST_SRC_WIDTH-1:0] src;
    logic [15:0]                   seed;
  } req_t;

  logic            clk_i;
  logic            rst_ni;
  logic            host_a_valid_i;
  logic            host_a_ready_o;
  tl_pkg::a_host_t host_a_i;
  logic            host_d_valid_o;
  logic            host_d_ready_i;
  tl_pkg::d_host_t host_d_o;

  req_t                      req_tbl [NumReq];
  logic [`TL_DATA_WIDTH-1:0] ref_mem [`TL_MEM_WORDS];
  tl_pkg::d_host_t           exp_q [$];
  int                        total_beats = 0;
  int                        rcv_beats   = 0;
  integer                    seed        = 32'h9e80_e236;

  tl_fifo_mem_top uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_valid_i (host_a_valid_i),
    .host_a_ready_o (host_a_ready_o),
    .host_a_i       (host_a_i),
    .host_d_valid_o (host_d_valid_o),
    .host_d_ready_i (host_d_ready_i),
    .host_d_o       (host_d_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(Period / 2) clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp));
    end
  endtask

  // Words of a message are 2**size bytes over 4 bytes each, never fewer than one.
  function automatic int words_in(input logic [`TL_SIZE_WIDTH-1:0] size);
    int n;
    n = (1 << size) / 4;
    words_in = (n == 0) ? 1 : n;
  endfunction

  function automatic logic [31:0] beat_data(input logic [15:0] s, input logic [7:0] idx);
    beat_data = {s, idx, ~s[7:0]};
  endfunction

  function automatic req_t make_req(input tl_pkg::a_op_e op, input logic [2:0] size,
                                    input logic [7:0] addr, input logic [3:0] src,
                                    input logic [15:0] s);
    make_req = '{op: op, size: size, addr: addr, src: src, seed: s};
  endfunction

  // Short and long latencies interleave. Reads only touch words written before.
  task automatic fill_table();
    req_tbl[0]  = make_req(tl_pkg::A_PUT_FULL_DATA, 3'd2, 8'h00, 4'd1,  16'h1001);
    req_tbl[1]  = make_req(tl_pkg::A_GET,           3'd2, 8'h00, 4'd2,  16'h0);
    req_tbl[2]  = make_req(tl_pkg::A_PUT_FULL_DATA, 3'd4, 8'h30, 4'd3,  16'h3003);
    req_tbl[3]  = make_req(tl_pkg::A_GET,           3'd4, 8'h30, 4'd4,  16'h0);
    req_tbl[4]  = make_req(tl_pkg::A_PUT_FULL_DATA, 3'd3, 8'h08, 4'd5,  16'h5005);
    req_tbl[5]  = make_req(tl_pkg::A_GET,           3'd3, 8'h08, 4'd6,  16'h0);
    req_tbl[6]  = make_req(tl_pkg::A_GET,           3'd2, 8'h00, 4'd7,  16'h0);
    req_tbl[7]  = make_req(tl_pkg::A_PUT_FULL_DATA, 3'd2, 8'h34, 4'd8,  16'h8008);
    req_tbl[8]  = make_req(tl_pkg::A_GET,           3'd4, 8'h30, 4'd9,  16'h0);
    req_tbl[9]  = make_req(tl_pkg::A_PUT_FULL_DATA, 3'd4, 8'h10, 4'd10, 16'ha00a);
    req_tbl[10] = make_req(tl_pkg::A_GET,           3'd2, 8'h14, 4'd11, 16'h0);
    req_tbl[11] = make_req(tl_pkg::A_PUT_FULL_DATA, 3'd3, 8'h28, 4'd12, 16'hc00c);
    req_tbl[12] = make_req(tl_pkg::A_GET,           3'd3, 8'h28, 4'd13, 16'h0);
    req_tbl[13] = make_req(tl_pkg::A_GET,           3'd4, 8'h10, 4'd14, 16'h0);
    req_tbl[14] = make_req(tl_pkg::A_GET,           3'd2, 8'h0c, 4'd15, 16'h0);
    req_tbl[15] = make_req(tl_pkg::A_GET,           3'd2, 8'h38, 4'd0,  16'h0);
  endtask

  // Updates the model in A order, queues the expected beats, then drives the A beats.
  task automatic send_request(input req_t r);
    int              n_a;
    int              base;
    int              i;
    logic            accepted;
    tl_pkg::d_host_t exp_beat;
    base            = int'(r.addr) / 4;
    exp_beat.size   = r.size;
    exp_beat.source = r.src;
    exp_beat.data   = '0;
    if (r.op == tl_pkg::A_PUT_FULL_DATA) begin
      n_a = words_in(r.size);
      for (i = 0; i < n_a; i++) begin
        ref_mem[(base + i) % `TL_MEM_WORDS] = beat_data(r.seed, 8'(i));
      end
      exp_beat.opcode = tl_pkg::D_ACCESS_ACK;
      exp_q.push_back(exp_beat);
      total_beats++;
    end else begin
      n_a = 1;
      exp_beat.opcode = tl_pkg::D_ACCESS_ACK_DATA;
      for (i = 0; i < words_in(r.size); i++) begin
        exp_beat.data = ref_mem[(base + i) % `TL_MEM_WORDS];
        exp_q.push_back(exp_beat);
        total_beats++;
      end
    end
    for (i = 0; i < n_a; i++) begin
      host_a_valid_i = 1'b1;
      host_a_i = '{opcode: r.op, size: r.size, source: r.src, address: r.addr,
                   data: (n_a > 1 || r.op == tl_pkg::A_PUT_FULL_DATA) ?
                         beat_data(r.seed, 8'(i)) : '0};
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk_i);
        accepted = host_a_ready_o;
      end
      @(negedge clk_i);
    end
    host_a_valid_i = 1'b0;
  endtask

  task automatic take_beat(input tl_pkg::d_host_t got);
    tl_pkg::d_host_t exp_beat;
    if (exp_q.size() == 0) begin
      stop_on_failure("a response beat arrived with no request waiting for it");
    end
    exp_beat = exp_q.pop_front();
    check_value(got.opcode, exp_beat.opcode, $sformatf("opcode of beat %0d", rcv_beats));
    check_value(got.size, exp_beat.size, $sformatf("size of beat %0d", rcv_beats));
    check_value(got.source, exp_beat.source, $sformatf("source of beat %0d", rcv_beats));
    if (exp_beat.opcode == tl_pkg::D_ACCESS_ACK_DATA) begin
      check_value(got.data, exp_beat.data, $sformatf("data of beat %0d", rcv_beats));
    end
    rcv_beats++;
  endtask

  //////////////////////////////
  // Processes
  //////////////////////////////

  // Random back-pressure on D, ready about three cycles in four.
  initial begin
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      host_d_ready_i = (($random(seed) & 3) != 0);
      @(posedge clk_i);
      if (host_d_valid_o && host_d_ready_i) begin
        take_beat(host_d_o);
      end
    end
  end

  initial begin
    #(LimitCycle * Period);
    stop_on_failure("timeout, responses stopped arriving before all requests completed");
  end

  initial begin
    int k;
    rst_ni         = 1'b0;
    host_a_valid_i = 1'b0;
    host_a_i       = '0;
    host_d_ready_i = 1'b0;
    fill_table();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_value(host_d_valid_o, 1'b0, "host_d_valid_o after reset");
    check_value(host_a_ready_o, 1'b1, "host_a_ready_o after reset");

    for (k = 0; k < NumReq; k++) begin
      send_request(req_tbl[k]);
    end
    while (rcv_beats < total_beats) begin
      @(posedge clk_i);
    end

    // Idle window so that any extra beat shows up.
    repeat (50) @(posedge clk_i);
    @(negedge clk_i);
    if (exp_q.size() == 0 && rcv_beats == total_beats && !host_d_valid_o) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_on_failure($sformatf("run ended with %0d of %0d beats received", rcv_beats,
                                total_beats));
    end
  end

endmodule

`default_nettype wire

// ==== common/tl_defines.svh ====
`ifndef TL_DEFINES_SVH
`define TL_DEFINES_SVH

// Bus geometry.
`define TL_DATA_WIDTH 32
`define TL_ADDR_WIDTH 8
`define TL_SIZE_WIDTH 3

// Largest transfer is 2**TL_MAX_SIZE bytes, four beats.
`define TL_MAX_SIZE 4

// Source IDs, the device width also sets the tracker depth.
`define TL_HOST_SRC_WIDTH 4
`define TL_DEV_SRC_WIDTH 2

// Backing store depth in words.
`define TL_MEM_WORDS 64

`endif

// ==== common/tl_pkg.sv ====
`default_nettype none

`include "tl_defines.svh"

package tl_pkg;

  // A channel opcodes.
  typedef enum logic [2:0] {
    A_PUT_FULL_DATA = 3'd0,
    A_GET           = 3'd4
  } a_op_e;

  // D channel opcodes.
  typedef enum logic [2:0] {
    D_ACCESS_ACK      = 3'd0,
    D_ACCESS_ACK_DATA = 3'd1
  } d_op_e;

  typedef struct packed {
    a_op_e                          opcode;
    logic [`TL_SIZE_WIDTH-1:0]      size;
    logic [`TL_HOST_SRC_WIDTH-1:0]  source;
    logic [`TL_ADDR_WIDTH-1:0]      address;
    logic [`TL_DATA_WIDTH-1:0]      data;
  } a_host_t;

  typedef struct packed {
    a_op_e                          opcode;
    logic [`TL_SIZE_WIDTH-1:0]      size;
    logic [`TL_DEV_SRC_WIDTH-1:0]   source;
    logic [`TL_ADDR_WIDTH-1:0]      address;
    logic [`TL_DATA_WIDTH-1:0]      data;
  } a_dev_t;

  typedef struct packed {
    d_op_e                          opcode;
    logic [`TL_SIZE_WIDTH-1:0]      size;
    logic [`TL_HOST_SRC_WIDTH-1:0]  source;
    logic [`TL_DATA_WIDTH-1:0]      data;
  } d_host_t;

  typedef struct packed {
    d_op_e                          opcode;
    logic [`TL_SIZE_WIDTH-1:0]      size;
    logic [`TL_DEV_SRC_WIDTH-1:0]   source;
    logic [`TL_DATA_WIDTH-1:0]      data;
  } d_dev_t;

  // Beats in a message: one word per beat, at least one beat.
  function automatic logic [`TL_SIZE_WIDTH-1:0] beat_count(
    input logic [`TL_SIZE_WIDTH-1:0] size,
    input logic                      multi
  );
    logic [`TL_SIZE_WIDTH-1:0] word_log2;
    word_log2 = `TL_SIZE_WIDTH'($clog2(`TL_DATA_WIDTH / 8));
    if (!multi || size <= word_log2) begin
      beat_count = `TL_SIZE_WIDTH'(1);
    end else begin
      beat_count = `TL_SIZE_WIDTH'(1) << (size - word_log2);
    end
  endfunction

endpackage

`default_nettype wire

// ==== fifo_converter/tl_burst_counter.sv ====
`default_nettype none

`include "tl_defines.svh"

module tl_burst_counter #(
  parameter int unsigned IdxWidth = $clog2(2 ** (`TL_MAX_SIZE - $clog2(`TL_DATA_WIDTH / 8)))
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      valid_i,
  input  wire logic                      ready_i,
  input  wire logic [`TL_SIZE_WIDTH-1:0] size_i,
  input  wire logic                      multi_i,
  output logic      [IdxWidth-1:0]       idx_o,
  output logic                           first_o,
  output logic                           last_o
);

  logic [IdxWidth-1:0]       idx_q;
  logic [`TL_SIZE_WIDTH-1:0] beats;

  // Single-beat messages end on their first beat.
  assign beats   = tl_pkg::beat_count(size_i, multi_i);
  assign idx_o   = idx_q;
  assign first_o = (idx_q == '0);
  assign last_o  = (idx_q == IdxWidth'(beats - 1'b1));

  // Advance on every transferred beat, wrap after the last one.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (valid_i && ready_i) begin
      if (last_o) begin
        idx_q <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // The sender must hold size steady through a burst,
  // else the index runs past the beat count.
  a_idx_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> (IdxWidth'(0) + idx_q) < beats
  ) else $error("burst index %0d outside beat count %0d", idx_q, beats);

endmodule

`default_nettype wire

// ==== fifo_converter/tl_fifo_converter.sv ====
`default_nettype none

`include "tl_defines.svh"

// Remaps host sources onto tracker slots and returns responses in request order.
module tl_fifo_converter (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  // Host side.
  input  wire logic             host_a_valid_i,
  output logic                  host_a_ready_o,
  input  wire tl_pkg::a_host_t  host_a_i,
  output logic                  host_d_valid_o,
  input  wire logic             host_d_ready_i,
  output tl_pkg::d_host_t       host_d_o,
  // Device side.
  output logic                  dev_a_valid_o,
  input  wire logic             dev_a_ready_i,
  output tl_pkg::a_dev_t        dev_a_o,
  input  wire logic             dev_d_valid_i,
  output logic                  dev_d_ready_o,
  input  wire tl_pkg::d_dev_t   dev_d_i
);

  localparam int unsigned NumSlots = 2 ** `TL_DEV_SRC_WIDTH;
  localparam int unsigned MaxBeats = 2 ** (`TL_MAX_SIZE - $clog2(`TL_DATA_WIDTH / 8));
  localparam int unsigned IdxWidth = $clog2(MaxBeats);

  typedef struct packed {
    tl_pkg::d_op_e             opcode;
    logic [`TL_SIZE_WIDTH-1:0] size;
  } d_ctrl_t;

  //////////////////////////////
  // Beat counters
  //////////////////////////////

  logic                host_a_first;
  logic                host_a_last;
  logic [IdxWidth-1:0] host_d_idx;
  logic                host_d_last;
  logic [IdxWidth-1:0] dev_d_idx;
  logic                dev_d_last;

  tl_burst_counter #(.IdxWidth(IdxWidth)) u_host_a_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (host_a_valid_i),
    .ready_i (host_a_ready_o),
    .size_i  (host_a_i.size),
    .multi_i (host_a_i.opcode == tl_pkg::A_PUT_FULL_DATA),
    .idx_o   (),
    .first_o (host_a_first),
    .last_o  (host_a_last)
  );

  tl_burst_counter #(.IdxWidth(IdxWidth)) u_host_d_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (host_d_valid_o),
    .ready_i (host_d_ready_i),
    .size_i  (host_d_o.size),
    .multi_i (host_d_o.opcode == tl_pkg::D_ACCESS_ACK_DATA),
    .idx_o   (host_d_idx),
    .first_o (),
    .last_o  (host_d_last)
  );

  tl_burst_counter #(.IdxWidth(IdxWidth)) u_dev_d_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (dev_d_valid_i),
    .ready_i (dev_d_ready_o),
    .size_i  (dev_d_i.size),
    .multi_i (dev_d_i.opcode == tl_pkg::D_ACCESS_ACK_DATA),
    .idx_o   (dev_d_idx),
    .first_o (),
    .last_o  (dev_d_last)
  );

  //////////////////////////////
  // Slot ring
  //////////////////////////////

  logic [NumSlots-1:0]                                 slot_valid_q, slot_valid_d;
  logic [NumSlots-1:0]                                 slot_ready_q, slot_ready_d;
  logic [NumSlots-1:0][`TL_HOST_SRC_WIDTH-1:0]         slot_src_q;
  d_ctrl_t [NumSlots-1:0]                              slot_ctrl_q;
  logic [NumSlots-1:0][MaxBeats-1:0][`TL_DATA_WIDTH-1:0] slot_data_q;
  logic [`TL_DEV_SRC_WIDTH-1:0]                        alloc_q, alloc_d;
  logic [`TL_DEV_SRC_WIDTH-1:0]                        rel_q, rel_d;
  logic                                                a_fire, d_fire, dev_fire;
  logic                                                a_blocked;

  // A new request needs the slot at the allocate pointer to be free.
  assign a_blocked = host_a_first && slot_valid_q[alloc_q];
  assign a_fire    = host_a_valid_i && host_a_ready_o;
  assign d_fire    = host_d_valid_o && host_d_ready_i;
  assign dev_fire  = dev_d_valid_i && dev_d_ready_o;

  always_comb begin
    slot_valid_d = slot_valid_q;
    slot_ready_d = slot_ready_q;
    alloc_d      = alloc_q;
    rel_d        = rel_q;

    if (dev_fire && dev_d_last) begin
      slot_ready_d[dev_d_i.source] = 1'b1;
    end

    // Head slot is freed by its last host D beat.
    if (d_fire && host_d_last) begin
      slot_valid_d[rel_q] = 1'b0;
      slot_ready_d[rel_q] = 1'b0;
      rel_d               = rel_q + 1'b1;
    end

    if (a_fire && host_a_first) begin
      slot_valid_d[alloc_q] = 1'b1;
    end
    if (a_fire && host_a_last) begin
      alloc_d = alloc_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= '0;
      slot_ready_q <= '0;
      alloc_q      <= '0;
      rel_q        <= '0;
    end else begin
      slot_valid_q <= slot_valid_d;
      slot_ready_q <= slot_ready_d;
      alloc_q      <= alloc_d;
      rel_q        <= rel_d;
    end
  end

  // Payload storage.
  always_ff @(posedge clk_i) begin
    if (a_fire && host_a_first) begin
      slot_src_q[alloc_q] <= host_a_i.source;
    end
    if (dev_fire) begin
      slot_ctrl_q[dev_d_i.source]            <= '{opcode: dev_d_i.opcode, size: dev_d_i.size};
      slot_data_q[dev_d_i.source][dev_d_idx] <= dev_d_i.data;
    end
  end

  //////////////////////////////
  // Channel outputs
  //////////////////////////////

  assign host_a_ready_o = dev_a_ready_i && !a_blocked;
  assign dev_a_valid_o  = host_a_valid_i && !a_blocked;
  assign dev_a_o        = '{opcode:  host_a_i.opcode,
                            size:    host_a_i.size,
                            source:  alloc_q,
                            address: host_a_i.address,
                            data:    host_a_i.data};

  // Every device beat has a slot waiting for it.
  assign dev_d_ready_o = 1'b1;

  assign host_d_valid_o = slot_ready_q[rel_q];
  assign host_d_o       = '{opcode: slot_ctrl_q[rel_q].opcode,
                            size:   slot_ctrl_q[rel_q].size,
                            source: slot_src_q[rel_q],
                            data:   slot_data_q[rel_q][host_d_idx]};

  // Responses may only come back for slots that were issued.
  a_dev_d_slot_live: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dev_d_valid_i |-> slot_valid_q[dev_d_i.source]
  ) else $error("device response to idle slot %0d", dev_d_i.source);

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/tl_pkg.sv
fifo_converter/tl_burst_counter.sv
fifo_converter/tl_fifo_converter.sv
source/tl_ooo_memory.sv
source/tl_fifo_mem_top.sv
bench/tb_tl_fifo_mem.sv

// ==== source/tl_fifo_mem_top.sv ====
`default_nettype none

module tl_fifo_mem_top (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             host_a_valid_i,
  output logic                  host_a_ready_o,
  input  wire tl_pkg::a_host_t  host_a_i,
  output logic                  host_d_valid_o,
  input  wire logic             host_d_ready_i,
  output tl_pkg::d_host_t       host_d_o
);

  // Device side links.
  logic            dev_a_valid;
  logic            dev_a_ready;
  tl_pkg::a_dev_t  dev_a;
  logic            dev_d_valid;
  logic            dev_d_ready;
  tl_pkg::d_dev_t  dev_d;

  tl_fifo_converter u_conv (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_valid_i (host_a_valid_i),
    .host_a_ready_o (host_a_ready_o),
    .host_a_i       (host_a_i),
    .host_d_valid_o (host_d_valid_o),
    .host_d_ready_i (host_d_ready_i),
    .host_d_o       (host_d_o),
    .dev_a_valid_o  (dev_a_valid),
    .dev_a_ready_i  (dev_a_ready),
    .dev_a_o        (dev_a),
    .dev_d_valid_i  (dev_d_valid),
    .dev_d_ready_o  (dev_d_ready),
    .dev_d_i        (dev_d)
  );

  tl_ooo_memory u_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid_i (dev_a_valid),
    .a_ready_o (dev_a_ready),
    .a_i       (dev_a),
    .d_valid_o (dev_d_valid),
    .d_ready_i (dev_d_ready),
    .d_o       (dev_d)
  );

endmodule

`default_nettype wire

// ==== source/tl_ooo_memory.sv ====
`default_nettype none

`include "tl_defines.svh"

// Word memory that answers each slot after an address-dependent delay.
module tl_ooo_memory (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            a_valid_i,
  output logic                 a_ready_o,
  input  wire tl_pkg::a_dev_t  a_i,
  output logic                 d_valid_o,
  input  wire logic            d_ready_i,
  output tl_pkg::d_dev_t       d_o
);

  localparam int unsigned NumSlots = 2 ** `TL_DEV_SRC_WIDTH;
  localparam int unsigned MaxBeats = 2 ** (`TL_MAX_SIZE - $clog2(`TL_DATA_WIDTH / 8));
  localparam int unsigned IdxWidth = $clog2(MaxBeats);
  localparam int unsigned WordAw   = $clog2(`TL_MEM_WORDS);
  localparam int unsigned LatWidth = 5;

  logic [`TL_MEM_WORDS-1:0][`TL_DATA_WIDTH-1:0]     mem_q;
  logic [NumSlots-1:0][MaxBeats-1:0][`TL_DATA_WIDTH-1:0] rbuf_q;
  logic [NumSlots-1:0][`TL_SIZE_WIDTH-1:0]          size_q;
  tl_pkg::d_op_e [NumSlots-1:0]                     op_q;
  logic [NumSlots-1:0]                              busy_q;
  logic [NumSlots-1:0][LatWidth-1:0]                lat_q;

  //////////////////////////////
  // Request side
  //////////////////////////////

  logic [IdxWidth-1:0]       a_idx_q;
  logic                      a_fire, a_first, a_last, a_put;
  logic [`TL_SIZE_WIDTH-1:0] a_beats;
  logic [WordAw-1:0]         a_base;

  // Requests are never refused.
  assign a_ready_o = 1'b1;
  assign a_fire    = a_valid_i && a_ready_o;
  assign a_put     = (a_i.opcode == tl_pkg::A_PUT_FULL_DATA);
  assign a_beats   = tl_pkg::beat_count(a_i.size, a_put);
  assign a_first   = (a_idx_q == '0);
  assign a_last    = (a_idx_q == IdxWidth'(a_beats - 1'b1));
  assign a_base    = a_i.address[WordAw+1:2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_idx_q <= '0;
    end else if (a_fire) begin
      a_idx_q <= a_last ? '0 : a_idx_q + 1'b1;
    end
  end

  // Writes land per beat and reads snapshot at accept, so data follows A order.
  always_ff @(posedge clk_i) begin
    if (a_fire && a_put) begin
      mem_q[a_base + WordAw'(a_idx_q)] <= a_i.data;
    end
    if (a_fire && !a_put) begin
      for (int i = 0; i < MaxBeats; i++) begin
        rbuf_q[a_i.source][i] <= mem_q[a_base + WordAw'(i)];
      end
    end
    if (a_fire && a_last) begin
      size_q[a_i.source] <= a_i.size;
      op_q[a_i.source]   <= a_put ? tl_pkg::D_ACCESS_ACK : tl_pkg::D_ACCESS_ACK_DATA;
    end
  end

  //////////////////////////////
  // Response side
  //////////////////////////////

  logic                         active_q;
  logic [`TL_DEV_SRC_WIDTH-1:0] cur_q;
  logic [IdxWidth-1:0]          d_idx_q;
  logic                         any_due;
  logic [`TL_DEV_SRC_WIDTH-1:0] pick;
  logic                         d_last;

  assign d_last = (d_idx_q == IdxWidth'(tl_pkg::beat_count(
                    size_q[cur_q], op_q[cur_q] == tl_pkg::D_ACCESS_ACK_DATA) - 1'b1));

  // Lowest expired slot wins.
  always_comb begin
    pick    = '0;
    any_due = 1'b0;
    for (int s = NumSlots - 1; s >= 0; s--) begin
      if (busy_q[s] && lat_q[s] == '0) begin
        pick    = `TL_DEV_SRC_WIDTH'(s);
        any_due = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= '0;
      lat_q    <= '0;
      active_q <= 1'b0;
      cur_q    <= '0;
      d_idx_q  <= '0;
    end else begin
      for (int s = 0; s < NumSlots; s++) begin
        if (busy_q[s] && lat_q[s] != '0) begin
          lat_q[s] <= lat_q[s] - 1'b1;
        end
      end
      // Delay is 2 plus 6 per step of address bits [5:4].
      if (a_fire && a_last) begin
        busy_q[a_i.source] <= 1'b1;
        lat_q[a_i.source]  <= LatWidth'(2 + 6 * a_i.address[5:4]);
      end
      if (!active_q && any_due) begin
        active_q <= 1'b1;
        cur_q    <= pick;
      end
      if (d_valid_o && d_ready_i) begin
        d_idx_q <= d_last ? '0 : d_idx_q + 1'b1;
        if (d_last) begin
          active_q      <= 1'b0;
          busy_q[cur_q] <= 1'b0;
        end
      end
    end
  end

  assign d_valid_o = active_q;
  assign d_o       = '{opcode: op_q[cur_q],
                       size:   size_q[cur_q],
                       source: cur_q,
                       data:   rbuf_q[cur_q][d_idx_q]};

  // The converter must not reuse a slot before its response has drained.
  a_slot_free: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (a_valid_i && a_first) |-> !busy_q[a_i.source]
  ) else $error("request for busy slot %0d", a_i.source);

endmodule

`default_nettype wire
